// ==== eeprom_pkg.sv ====
package eeprom_pkg;

    // device type code, top nibble of every control byte
    localparam logic [3:0] dev_code = 4'b1010;

    typedef enum logic {
        op_write,
        op_read
    } eeprom_op_t;

    typedef struct packed {
        logic [10:0] addr; // [10:8] page select, [7:0] word address
        logic [7:0]  data;
    } eeprom_req_t;

    // sda 0 pulls the line low, 1 releases it
    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_bus_t;

    // controller sequencer, one-hot
    typedef enum logic [10:0] {
        idle        = 11'b000_0000_0001,
        ready       = 11'b000_0000_0010,
        write_start = 11'b000_0000_0100,
        ctrl_write  = 11'b000_0000_1000,
        addr_write  = 11'b000_0001_0000,
        data_write  = 11'b000_0010_0000,
        read_start  = 11'b000_0100_0000,
        ctrl_read   = 11'b000_1000_0000,
        data_read   = 11'b001_0000_0000,
        stop        = 11'b010_0000_0000,
        ackn        = 11'b100_0000_0000
    } main_state_t;

    typedef enum logic [2:0] {
        s_idle,
        s_ctrl,
        s_addr,
        s_data_in,
        s_data_out,
        s_ack,
        s_program
    } slave_state_t;

endpackage

// ==== eeprom_wr.sv ====
`timescale 1ns/1ns

module eeprom_wr import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    input  i2c_bus_t    bus,
    output i2c_bus_t    m_bus,
    output logic [7:0]  rd_data,
    output logic        ack,
    output logic        busy
);

    main_state_t state;
    eeprom_op_t  op;
    eeprom_req_t req_q;

    logic [7:0] sh;      // shared byte shifter, msb goes out first
    logic [3:0] bit_cnt;
    logic [1:0] step;    // sub-step of start and stop conditions
    logic       retry;   // control byte refused, poll again after stop

    logic [7:0] ctrl_wr;
    logic [7:0] ctrl_rd;
    logic [7:0] start_byte;
    logic [7:0] next_byte;

    assign ctrl_wr    = {dev_code, req_q.addr[10:8], 1'b0};
    assign ctrl_rd    = {dev_code, req_q.addr[10:8], 1'b1};
    assign start_byte = (state == read_start) ? ctrl_rd : ctrl_wr;
    assign next_byte  = (state == ctrl_write) ? req_q.addr[7:0] : req_q.data;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= idle;
            op      <= op_write;
            m_bus   <= '{scl: 1'b1, sda: 1'b1};
            ack     <= 1'b0;
            busy    <= 1'b0;
            bit_cnt <= '0;
            step    <= '0;
            retry   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    ack <= 1'b0;
                    if (wr || rd) begin
                        op    <= wr ? op_write : op_read; // wr wins
                        req_q <= req;
                        busy  <= 1'b1;
                        state <= ready;
                    end
                end

                ready: begin
                    step  <= '0;
                    retry <= 1'b0;
                    state <= write_start;
                end

                // start or repeated start, works from scl low or an idle bus
                write_start, read_start: begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: m_bus.sda <= 1'b1;
                        2'd1: m_bus.scl <= 1'b1;
                        2'd2: m_bus.sda <= 1'b0; // sda falls, scl high
                        default: begin
                            m_bus.scl <= 1'b0;
                            m_bus.sda <= start_byte[7];
                            sh        <= {start_byte[6:0], 1'b0};
                            bit_cnt   <= 4'd1;
                            state     <= (state == read_start) ? ctrl_read : ctrl_write;
                        end
                    endcase
                end

                ctrl_write, addr_write, data_write, ctrl_read: begin
                    m_bus.scl <= ~m_bus.scl;
                    if (m_bus.scl) begin // end of high phase
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt < 4'd8) begin
                            m_bus.sda <= sh[7];
                            sh        <= {sh[6:0], 1'b0};
                        end else if (bit_cnt == 4'd8) begin
                            m_bus.sda <= 1'b1; // let the slave answer
                        end else begin
                            // ack slot, low sda means acknowledged
                            bit_cnt <= '0;
                            step    <= '0;
                            case (state)
                                ctrl_write: begin
                                    if (!bus.sda) begin
                                        m_bus.sda <= next_byte[7];
                                        sh        <= {next_byte[6:0], 1'b0};
                                        bit_cnt   <= 4'd1;
                                        state     <= addr_write;
                                    end else begin
                                        retry <= 1'b1; // still programming
                                        state <= stop;
                                    end
                                end
                                addr_write: begin
                                    if (bus.sda) begin
                                        state <= stop;
                                    end else if (op == op_write) begin
                                        m_bus.sda <= next_byte[7];
                                        sh        <= {next_byte[6:0], 1'b0};
                                        bit_cnt   <= 4'd1;
                                        state     <= data_write;
                                    end else begin
                                        state <= read_start;
                                    end
                                end
                                ctrl_read: begin
                                    state <= bus.sda ? stop : data_read;
                                end
                                default: state <= stop; // data_write done
                            endcase
                        end
                    end
                end

                // sda stays released, so the ninth bit is a nack
                data_read: begin
                    m_bus.scl <= ~m_bus.scl;
                    if (m_bus.scl) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt < 4'd8) begin
                            sh <= {sh[6:0], bus.sda};
                        end else begin
                            rd_data <= sh;
                            bit_cnt <= '0;
                            step    <= '0;
                            state   <= stop;
                        end
                    end
                end

                stop: begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: m_bus.sda <= 1'b0;
                        2'd1: m_bus.scl <= 1'b1;
                        2'd2: m_bus.sda <= 1'b1; // sda rises, scl high
                        default: begin
                            if (retry) begin
                                retry <= 1'b0;
                                state <= write_start;
                            end else begin
                                state <= ackn;
                            end
                        end
                    endcase
                end

                ackn: begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= idle;
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== eeprom_slave.sv ====
`timescale 1ns/1ns

module eeprom_slave import eeprom_pkg::*; #(
    parameter int WRITE_CYCLES = 200
) (
    input  logic     CLK,
    input  logic     RESET,
    input  i2c_bus_t bus,
    output logic     s_sda_low
);

    localparam int CW = $clog2(WRITE_CYCLES + 1);

    slave_state_t state;
    slave_state_t after_ack; // where to go once the ack bit is over
    i2c_bus_t     bus_q;

    logic [7:0]    shreg;
    logic [7:0]    word;
    logic [2:0]    page;
    logic [2:0]    bit_cnt;
    logic          pending;  // byte stored and waiting for stop
    logic [CW-1:0] prog_cnt;

    logic [7:0] mem [2048];

    logic        start_det;
    logic        stop_det;
    logic        scl_rise;
    logic        mem_we;
    logic [7:0]  in_byte;
    logic [7:0]  rd_byte;
    logic [10:0] mem_addr;

    assign start_det = bus_q.scl & bus.scl & bus_q.sda & ~bus.sda;
    assign stop_det  = bus_q.scl & bus.scl & ~bus_q.sda & bus.sda;
    assign scl_rise  = ~bus_q.scl & bus.scl;

    assign in_byte  = {shreg[6:0], bus.sda};
    assign mem_addr = {page, word};
    assign rd_byte  = mem[mem_addr];
    assign mem_we   = scl_rise && (state == s_data_in) && (bit_cnt == 3'd7);

    // erased device
    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hff;
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_we) begin
            mem[mem_addr] <= in_byte;
        end
    end

    // scl is high for one cycle per bit so a detected rise coincides with scl falling
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= s_idle;
            after_ack <= s_idle;
            bus_q     <= '{scl: 1'b1, sda: 1'b1};
            s_sda_low <= 1'b0;
            bit_cnt   <= '0;
            pending   <= 1'b0;
            prog_cnt  <= '0;
        end else begin
            bus_q <= bus;
            if (prog_cnt != '0) begin
                prog_cnt <= prog_cnt - CW'(1);
            end

            if (start_det) begin
                s_sda_low <= 1'b0;
                bit_cnt   <= '0;
                state     <= s_ctrl;
            end else if (stop_det) begin
                s_sda_low <= 1'b0;
                if (pending) begin
                    pending  <= 1'b0;
                    prog_cnt <= CW'(WRITE_CYCLES);
                    state    <= s_program;
                end else begin
                    state <= (prog_cnt != '0) ? s_program : s_idle;
                end
            end else begin
                case (state)
                    s_ctrl, s_addr, s_data_in: begin
                        if (scl_rise) begin
                            shreg   <= in_byte;
                            bit_cnt <= bit_cnt + 3'd1; // wraps to 0 after a byte
                            if (bit_cnt == 3'd7) begin
                                case (state)
                                    s_ctrl: begin
                                        if (in_byte[7:4] == dev_code && prog_cnt == '0) begin
                                            page      <= in_byte[3:1];
                                            after_ack <= in_byte[0] ? s_data_out : s_addr;
                                            s_sda_low <= 1'b1;
                                            state     <= s_ack;
                                        end else begin
                                            // no ack while programming or for another device
                                            state <= (prog_cnt != '0) ? s_program : s_idle;
                                        end
                                    end
                                    s_addr: begin
                                        word      <= in_byte;
                                        after_ack <= s_data_in;
                                        s_sda_low <= 1'b1;
                                        state     <= s_ack;
                                    end
                                    default: begin
                                        pending   <= 1'b1;
                                        after_ack <= s_idle;
                                        s_sda_low <= 1'b1;
                                        state     <= s_ack;
                                    end
                                endcase
                            end
                        end
                    end

                    s_ack: begin
                        if (scl_rise) begin
                            state <= after_ack;
                            if (after_ack == s_data_out) begin
                                s_sda_low <= ~rd_byte[7]; // first data bit
                                shreg     <= {rd_byte[6:0], 1'b0};
                            end else begin
                                s_sda_low <= 1'b0;
                            end
                        end
                    end

                    s_data_out: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                s_sda_low <= 1'b0; // master answers next
                                after_ack <= s_idle;
                                state     <= s_ack;
                            end else begin
                                s_sda_low <= ~shreg[7];
                                shreg     <= {shreg[6:0], 1'b0};
                            end
                        end
                    end

                    s_program: begin
                        if (prog_cnt == '0) begin
                            state <= s_idle;
                        end
                    end

                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== eeprom_sys.sv ====
`timescale 1ns/1ns

module eeprom_sys import eeprom_pkg::*; #(
    parameter int WRITE_CYCLES = 200
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    output logic [7:0]  rd_data,
    output logic        ack,
    output logic        busy,
    output i2c_bus_t    bus
);

    i2c_bus_t m_bus;
    logic     s_sda_low;

    // open-drain sda, scl from the master only
    assign bus.scl = m_bus.scl;
    assign bus.sda = m_bus.sda & ~s_sda_low;

    eeprom_wr u_wr (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .req     (req),
        .bus     (bus),
        .m_bus   (m_bus),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy)
    );

    eeprom_slave #(
        .WRITE_CYCLES (WRITE_CYCLES)
    ) u_slave (
        .CLK       (CLK),
        .RESET     (RESET),
        .bus       (bus),
        .s_sda_low (s_sda_low)
    );

endmodule

// ==== tb_eeprom_table.svh ====
`ifndef TB_EEPROM_TABLE_SVH
`define TB_EEPROM_TABLE_SVH

// one row per host request, columns are op, addr, data, busy_ign
// busy_ign set means the request is strobed while a read of the same
// address is running, and the DUT has to drop it

typedef struct packed {
    eeprom_op_t  op;
    logic [10:0] addr;
    logic [7:0]  data;
    logic        busy_ign;
} tb_entry_t;

localparam int n_fixed = 17;

localparam tb_entry_t fixed_tab [n_fixed] = '{
    '{op_write, 11'h005, 8'ha1, 1'b0}, // same word, three pages
    '{op_write, 11'h105, 8'hb2, 1'b0}, // slave still programming here
    '{op_write, 11'h705, 8'hc3, 1'b0},
    '{op_read,  11'h005, 8'h00, 1'b0},
    '{op_read,  11'h105, 8'h00, 1'b0},
    '{op_read,  11'h705, 8'h00, 1'b0},
    '{op_read,  11'h3ff, 8'h00, 1'b0}, // never written, erased value
    '{op_write, 11'h010, 8'h00, 1'b0},
    '{op_read,  11'h010, 8'h00, 1'b0},
    '{op_write, 11'h455, 8'h5a, 1'b0},
    '{op_read,  11'h455, 8'h00, 1'b0},
    '{op_write, 11'h455, 8'hff, 1'b0},
    '{op_read,  11'h455, 8'h00, 1'b0},
    '{op_write, 11'h005, 8'h3c, 1'b1}, // write while busy
    '{op_read,  11'h005, 8'h00, 1'b0}, // still a1
    '{op_read,  11'h105, 8'h00, 1'b1}, // read while busy
    '{op_read,  11'h105, 8'h00, 1'b0}
};

`endif

// ==== tb_eeprom_sys.sv ====
`timescale 1ns/1ns

module tb_eeprom_sys import eeprom_pkg::*; ();

    `include "tb_eeprom_table.svh"

    localparam int write_cycles = 200;
    localparam int n_rand       = 8;  // four write/read pairs from $random
    localparam int n_entries    = n_fixed + n_rand;
    localparam int cycle_limit  = n_entries * (300 + write_cycles);

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    eeprom_req_t req;
    logic [7:0]  rd_data;
    logic        ack;
    logic        busy;
    i2c_bus_t    bus;

    logic [7:0] shadow [2048]; // expected memory contents
    tb_entry_t  tab [$];
    int         seed;
    int         cycle_cnt = 0;

    eeprom_sys #(
        .WRITE_CYCLES (write_cycles)
    ) uut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .req     (req),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .bus     (bus)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            report_fail($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            report_fail($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
        end
    endtask

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            report_fail($sformatf("timeout: tests did not finish within %0d clock cycles",
                                  cycle_limit));
        end
    end

    // one-cycle strobe starting at a falling edge
    task automatic send_strobe(input tb_entry_t e);
        wr  = (e.op == op_write);
        rd  = (e.op == op_read);
        req = '{addr: e.addr, data: e.data};
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        while (ack !== 1'b1) begin
            @(negedge CLK);
        end
    endtask

    task automatic run_entry(input tb_entry_t e);
        tb_entry_t carrier;
        carrier = e;
        if (e.busy_ign) begin
            carrier.op = op_read; // real transaction that keeps the DUT busy
        end
        send_strobe(carrier);
        check_bit("busy", busy, 1'b1);
        check_bit("ack", ack, 1'b0);   // previous ack lasted one cycle
        if (e.busy_ign) begin
            repeat (5) @(negedge CLK);
            check_bit("busy", busy, 1'b1);
            send_strobe(e);
        end
        wait_ack();
        check_bit("busy", busy, 1'b0);
        if (carrier.op == op_write) begin
            shadow[carrier.addr] = carrier.data;
        end else begin
            check_byte("rd_data", rd_data, shadow[carrier.addr]);
        end
        if (e.busy_ign) begin
            // a dropped strobe must not start anything
            repeat (20) begin
                @(negedge CLK);
                check_bit("ack", ack, 1'b0);
                check_bit("busy", busy, 1'b0);
            end
        end
    endtask

    initial begin
        tb_entry_t e;
        seed  = 38;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        req   = '0;
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = 8'hff;
        end
        for (int i = 0; i < n_fixed; i++) begin
            tab.push_back(fixed_tab[i]);
        end
        for (int i = 0; i < n_rand / 2; i++) begin
            e.op       = op_write;
            e.addr     = 11'($random(seed));
            e.data     = 8'($random(seed));
            e.busy_ign = 1'b0;
            tab.push_back(e);
            e.op = op_read;
            tab.push_back(e);
        end

        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        // idle bus after reset
        check_bit("ack", ack, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("bus.scl", bus.scl, 1'b1);
        check_bit("bus.sda", bus.sda, 1'b1);

        foreach (tab[i]) begin
            run_entry(tab[i]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== eeprom_sys.f ====
+incdir+.
eeprom_pkg.sv
eeprom_wr.sv
eeprom_slave.sv
eeprom_sys.sv
tb_eeprom_sys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_sys
RTL_TOP   ?= eeprom_sys
FILELIST  ?= eeprom_sys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
